// ==== common/prefetch_consts.svh ====
// --------------------
// prefetch constants
// startup fetch window, memory word size and queue sizing
// --------------------

`ifndef PREFETCH_CONSTS_SVH
`define PREFETCH_CONSTS_SVH

// first fetch after system reset, 16 bytes below 1M
`define STARTUP_PREFETCH_LINEAR 32'h000FFFF0

// bytes fetchable before a restart loads a real code segment
`define STARTUP_PREFETCH_LIMIT  32'h00000010

// bytes per memory read
`define MEM_WORD_BYTES          4

// queue slots, the pointer width must match
`define PREFETCH_FIFO_DEPTH     8
`define PREFETCH_FIFO_AW        3

`endif

// ==== common/prefetch_pkg.sv ====
// --------------------
// prefetch package
// segment descriptor, fetch request and prefetch queue entry types
// shared by the tracker, the fetch engine and the queue
// --------------------

`default_nettype none

package prefetch_pkg;

    // x86 segment descriptor, bit 0 is limit_low[0]
    typedef struct packed {
        logic [7:0]  base_high;   // base[31:24]
        logic [3:0]  flags;       // g, d/b, l, avl
        logic [3:0]  limit_high;  // limit[19:16]
        logic [7:0]  access;      // p, dpl, s, type
        logic [23:0] base_low;    // base[23:0]
        logic [15:0] limit_low;   // limit[15:0]
    } seg_desc_t;

    // flags[3] is the granularity bit
    localparam int unsigned desc_flag_g = 3;

    // one prefetch request, at most one memory word
    typedef struct packed {
        logic [31:0] address;     // linear byte address
        logic [4:0]  length;      // 0..4 bytes wanted
        logic        su;          // 1 = user (cpl 3)
    } fetch_req_t;

    // one prefetch queue slot
    // either a chunk of code bytes or the end-of-segment marker
    typedef struct packed {
        logic [31:0] data;        // lowest address in data[7:0]
        logic [2:0]  count;       // valid bytes, 0 for a marker
        logic        limit_fault; // end-of-segment marker
    } fifo_entry_t;

endpackage

`default_nettype wire

// ==== prefetch/prefetch.sv ====
// --------------------
// prefetch tracker
// keeps the linear fetch address and the bytes left before the
// code segment limit, sizes each request to one memory word
// and flags the end of the segment once per restart
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetch (
    input  wire logic                   clk,
    input  wire logic                   pr_reset,
    input  wire logic                   fetch_restart,

    input  wire logic [1:0]             cpl,
    input  wire logic [31:0]            eip,
    input  wire prefetch_pkg::seg_desc_t cs_desc,

    input  wire logic                   prefetched_do,
    input  wire logic [4:0]             prefetched_length,

    output      prefetch_pkg::fetch_req_t fetch_req,
    output      logic                   limit_signal
);

    import prefetch_pkg::*;

    localparam logic [31:0] word_bytes = `MEM_WORD_BYTES;

    logic [31:0] linear;          // next byte to fetch
    logic [31:0] limit;           // bytes left in the segment
    logic        limit_signaled;  // marker already sent

    logic [31:0] cs_base;
    logic [31:0] cs_limit;
    logic [4:0]  charged;         // bytes taken off the window

    // descriptor decode
    assign cs_base = {cs_desc.base_high, cs_desc.base_low};

    always_comb begin
        if (cs_desc.flags[desc_flag_g]) begin
            cs_limit = {cs_desc.limit_high, cs_desc.limit_low, 12'hFFF};  // 4k pages
        end else begin
            cs_limit = {12'd0, cs_desc.limit_high, cs_desc.limit_low};
        end
    end

    // request is one word or whatever is left of the segment
    assign fetch_req.address = linear;
    assign fetch_req.length  = (limit > word_bytes) ? word_bytes[4:0] : limit[4:0];
    assign fetch_req.su      = (cpl == 2'd3);  // user code

    // never charge more than the window holds
    assign charged = (limit < {27'd0, prefetched_length}) ? limit[4:0] : prefetched_length;

    // end of segment, exactly once until the next restart
    assign limit_signal = (limit == 32'd0) && !limit_signaled;

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            linear <= `STARTUP_PREFETCH_LINEAR;
            limit  <= `STARTUP_PREFETCH_LIMIT;
        end else if (fetch_restart) begin
            linear <= cs_base + eip;
            // eip past the limit leaves an empty window
            limit  <= (cs_limit >= eip) ? cs_limit - eip + 32'd1 : 32'd0;
        end else if (prefetched_do) begin
            linear <= linear + {27'd0, charged};
            limit  <= limit - {27'd0, charged};
        end
    end

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            limit_signaled <= 1'b0;
        end else if (fetch_restart) begin
            limit_signaled <= 1'b0;  // new window, new marker
        end else if (limit_signal) begin
            limit_signaled <= 1'b1;
        end
    end

    // the engine never reports more bytes than were asked for
    a_fetched_within_request: assert property (
        @(posedge clk) disable iff (pr_reset)
        prefetched_do |-> (prefetched_length <= fetch_req.length)
    ) else $error("prefetched_length %0d above requested %0d",
                  prefetched_length, fetch_req.length);

endmodule

`default_nettype wire

// ==== prefetch/fetch_engine.sv ====
// --------------------
// fetch engine
// one aligned word read at a time, extracts the requested bytes
// and hands them to the prefetch queue as a chunk
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module fetch_engine (
    input  wire logic                      clk,
    input  wire logic                      pr_reset,
    input  wire logic                      fetch_restart,

    input  wire prefetch_pkg::fetch_req_t  fetch_req,
    input  wire logic [`PREFETCH_FIFO_AW:0] fifo_count,

    output      logic                      mem_read_do,
    output      logic [31:0]               mem_address,
    output      logic                      mem_su,
    input  wire logic                      mem_done,
    input  wire logic [31:0]               mem_data,

    output      logic                      prefetched_do,
    output      logic [4:0]                prefetched_length,
    output      logic                      chunk_push,
    output      prefetch_pkg::fifo_entry_t chunk
);

    // start only below depth-1, the last slot is kept for the marker
    localparam logic [`PREFETCH_FIFO_AW:0] fifo_start_max =
        (`PREFETCH_FIFO_AW + 1)'(`PREFETCH_FIFO_DEPTH - 1);

    logic        busy;     // read in flight
    logic        stale;    // restart seen while in flight
    logic [1:0]  offset;   // byte offset inside the word
    logic [4:0]  req_len;  // bytes asked for at issue
    logic        start;
    logic        read_end;
    logic [4:0]  avail;    // bytes from offset to end of word
    logic [4:0]  use_len;
    logic [31:0] shifted;
    logic [31:0] keep;

    assign start = !busy && !fetch_restart
                && (fetch_req.length != 5'd0)
                && (fifo_count < fifo_start_max);

    assign read_end = busy && mem_done;

    always_ff @(posedge clk) begin
        if (pr_reset) begin
            busy  <= 1'b0;
            stale <= 1'b0;
        end else if (read_end) begin
            busy  <= 1'b0;  // drops on the done edge
            stale <= 1'b0;
        end else if (start) begin
            busy  <= 1'b1;
            stale <= 1'b0;
        end else if (busy && fetch_restart) begin
            stale <= 1'b1;  // keep the read, drop its data later
        end
    end

    // request capture, held for the whole read
    always_ff @(posedge clk) begin
        if (start) begin
            mem_address <= {fetch_req.address[31:2], 2'b00};
            mem_su      <= fetch_req.su;
            offset      <= fetch_req.address[1:0];
            req_len     <= fetch_req.length;
        end
    end

    assign mem_read_do = busy;

    // byte extraction
    assign avail   = 5'(`MEM_WORD_BYTES) - {3'd0, offset};
    assign use_len = (req_len < avail) ? req_len : avail;
    assign shifted = mem_data >> {offset, 3'b000};  // first wanted byte to the bottom

    always_comb begin
        for (int k = 0; k < `MEM_WORD_BYTES; k++) begin
            keep[8*k +: 8] = (k < use_len) ? 8'hFF : 8'h00;  // clear unused bytes
        end
    end

    assign prefetched_do     = read_end && !stale;
    assign prefetched_length = use_len;
    assign chunk_push        = read_end && !stale;

    assign chunk.data        = shifted & keep;
    assign chunk.count       = use_len[2:0];
    assign chunk.limit_fault = 1'b0;

    // memory answers only a read that is in flight
    a_done_with_read: assert property (
        @(posedge clk) disable iff (pr_reset)
        mem_done |-> mem_read_do
    ) else $error("mem_done without an outstanding read");

endmodule

`default_nettype wire

// ==== prefetch/prefetch_fifo.sv ====
// --------------------
// prefetch queue
// circular buffer of fetched chunks and limit markers
// emptied on restart, head shown on fifo_entry
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetch_fifo (
    input  wire logic                      clk,
    input  wire logic                      pr_reset,
    input  wire logic                      fetch_restart,

    input  wire logic                      chunk_push,
    input  wire prefetch_pkg::fifo_entry_t chunk,
    input  wire logic                      limit_signal,

    output      logic [`PREFETCH_FIFO_AW:0] fifo_count,

    input  wire logic                      fifo_pop,
    output      prefetch_pkg::fifo_entry_t fifo_entry,
    output      logic                      fifo_valid
);

    import prefetch_pkg::*;

    localparam logic [`PREFETCH_FIFO_AW:0] depth =
        (`PREFETCH_FIFO_AW + 1)'(`PREFETCH_FIFO_DEPTH);

    fifo_entry_t mem [`PREFETCH_FIFO_DEPTH];

    logic [`PREFETCH_FIFO_AW-1:0] wr_ptr;
    logic [`PREFETCH_FIFO_AW-1:0] rd_ptr;
    logic                         push;
    logic                         pop;
    fifo_entry_t                  push_entry;
    fifo_entry_t                  marker;

    // end of segment marker carries no bytes
    assign marker.data        = '0;
    assign marker.count       = 3'd0;
    assign marker.limit_fault = 1'b1;

    assign push       = chunk_push || limit_signal;  // never both at once
    assign push_entry = limit_signal ? marker : chunk;
    assign pop        = fifo_pop && fifo_valid;

    // storage, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (pr_reset || fetch_restart) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fifo_count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   fifo_count <= fifo_count + 1'b1;
                2'b01:   fifo_count <= fifo_count - 1'b1;
                default: fifo_count <= fifo_count;  // both or neither
            endcase
        end
    end

    assign fifo_valid = (fifo_count != '0);
    assign fifo_entry = mem[rd_ptr];

    // the engine back-pressure must keep a slot for every push
    a_no_push_when_full: assert property (
        @(posedge clk) disable iff (pr_reset || fetch_restart)
        push |-> (fifo_count < depth)
    ) else $error("push into a full prefetch queue");

    // consumer pops only a valid head
    a_no_pop_when_empty: assert property (
        @(posedge clk) disable iff (pr_reset)
        fifo_pop |-> fifo_valid
    ) else $error("pop from an empty prefetch queue");

endmodule

`default_nettype wire

// ==== rtl/prefetch_top.sv ====
// --------------------
// prefetch top
// tracker, fetch engine and queue between the memory port
// and the decoder-side consumer
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module prefetch_top (
    input  wire logic                      clk,
    input  wire logic                      pr_reset,
    input  wire logic                      fetch_restart,

    input  wire logic [1:0]                cpl,
    input  wire logic [31:0]               eip,
    input  wire prefetch_pkg::seg_desc_t   cs_desc,

    output      logic                      mem_read_do,
    output      logic [31:0]               mem_address,
    output      logic                      mem_su,
    input  wire logic                      mem_done,
    input  wire logic [31:0]               mem_data,

    input  wire logic                      fifo_pop,
    output      prefetch_pkg::fifo_entry_t fifo_entry,
    output      logic                      fifo_valid
);

    import prefetch_pkg::*;

    fetch_req_t                   fetch_req;          // tracker to engine
    logic                         prefetched_do;      // engine done pulse
    logic [4:0]                   prefetched_length;
    logic                         limit_signal;       // marker push
    logic                         chunk_push;
    fifo_entry_t                  chunk;
    logic [`PREFETCH_FIFO_AW:0]   fifo_count;         // back-pressure

    prefetch i_prefetch (
        .clk               (clk),
        .pr_reset          (pr_reset),
        .fetch_restart     (fetch_restart),
        .cpl               (cpl),
        .eip               (eip),
        .cs_desc           (cs_desc),
        .prefetched_do     (prefetched_do),
        .prefetched_length (prefetched_length),
        .fetch_req         (fetch_req),
        .limit_signal      (limit_signal)
    );

    fetch_engine i_fetch_engine (
        .clk               (clk),
        .pr_reset          (pr_reset),
        .fetch_restart     (fetch_restart),
        .fetch_req         (fetch_req),
        .fifo_count        (fifo_count),
        .mem_read_do       (mem_read_do),
        .mem_address       (mem_address),
        .mem_su            (mem_su),
        .mem_done          (mem_done),
        .mem_data          (mem_data),
        .prefetched_do     (prefetched_do),
        .prefetched_length (prefetched_length),
        .chunk_push        (chunk_push),
        .chunk             (chunk)
    );

    prefetch_fifo i_prefetch_fifo (
        .clk               (clk),
        .pr_reset          (pr_reset),
        .fetch_restart     (fetch_restart),
        .chunk_push        (chunk_push),
        .chunk             (chunk),
        .limit_signal      (limit_signal),
        .fifo_count        (fifo_count),
        .fifo_pop          (fifo_pop),
        .fifo_entry        (fifo_entry),
        .fifo_valid        (fifo_valid)
    );

endmodule

`default_nettype wire

// ==== verif/tb_prefetch_top.sv ====
// --------------------
// prefetch top testbench
// directed tests against a memory model with random latency,
// expected chunk streams built from start address and window
// --------------------

`timescale 1ns/1ps
`default_nettype none

`include "prefetch_consts.svh"

module tb_prefetch_top;

    import prefetch_pkg::*;

    localparam int timeout = 200;  // cycles allowed per wait

    logic        clk = 1'b0;
    logic        pr_reset;
    logic        fetch_restart;
    logic [1:0]  cpl;
    logic [31:0] eip;
    seg_desc_t   cs_desc;
    logic        mem_read_do;
    logic [31:0] mem_address;
    logic        mem_su;
    logic        mem_done;
    logic [31:0] mem_data;
    logic        fifo_pop;
    fifo_entry_t fifo_entry;
    logic        fifo_valid;

    integer      seed = 21;
    int          mismatch_count = 0;
    int          failure_count = 0;  // timeouts, missing reads
    logic        mem_active;         // memory model busy with a read
    logic        mem_hold;           // stalls the answer while set
    int          mem_wait;
    logic [31:0] req_addr_q[$];      // reads seen since the last restart
    logic        req_su_q[$];

    prefetch_top i_dut (
        .clk           (clk),
        .pr_reset      (pr_reset),
        .fetch_restart (fetch_restart),
        .cpl           (cpl),
        .eip           (eip),
        .cs_desc       (cs_desc),
        .mem_read_do   (mem_read_do),
        .mem_address   (mem_address),
        .mem_su        (mem_su),
        .mem_done      (mem_done),
        .mem_data      (mem_data),
        .fifo_pop      (fifo_pop),
        .fifo_entry    (fifo_entry),
        .fifo_valid    (fifo_valid)
    );

    always #50 clk = ~clk;  // 100 ns period

    // byte k of the word at addr is the low byte of addr + k
    function automatic logic [31:0] word_pattern(input logic [31:0] addr);
        logic [31:0] w;
        for (int k = 0; k < 4; k++) begin
            w[8*k +: 8] = addr[7:0] + 8'(k);
        end
        return w;
    endfunction

    // memory model, answers 1 to 4 cycles after it sees a read
    always @(negedge clk) begin
        if (pr_reset) begin
            mem_done   <= 1'b0;
            mem_active <= 1'b0;
            mem_wait   <= 0;
            req_addr_q.delete();
            req_su_q.delete();
        end else if (mem_done) begin
            mem_done   <= 1'b0;  // one cycle only
            mem_active <= 1'b0;
        end else if (mem_read_do && !mem_active) begin
            mem_active <= 1'b1;
            mem_wait   <= 1 + ($unsigned($random(seed)) % 4);
            req_addr_q.push_back(mem_address);
            req_su_q.push_back(mem_su);
        end else if (mem_active) begin
            if (mem_wait <= 1 && !mem_hold) begin
                mem_done <= 1'b1;
                mem_data <= word_pattern(mem_address);
            end else if (mem_wait > 1) begin
                mem_wait <= mem_wait - 1;
            end
        end
    end

    task automatic check_entry(input fifo_entry_t got, input fifo_entry_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: entry data %h count %0d fault %b", $time,
                     got.data, got.count, got.limit_fault);
            $display("    expected data %h count %0d fault %b",
                     exp.data, exp.count, exp.limit_fault);
        end
    endtask

    task automatic check_request(input logic [31:0] got_addr, input logic got_su,
                                 input logic [31:0] exp_addr, input logic exp_su);
        if (got_addr !== exp_addr || got_su !== exp_su) begin
            mismatch_count++;
            $display("MISMATCH at %0t: read at %h su %b, expected %h su %b", $time,
                     got_addr, got_su, exp_addr, exp_su);
        end
    endtask

    task automatic compare_count(input int got, input int exp, input string what);
        if (got != exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    // load a byte-granular or page-granular code segment and restart
    task automatic restart(input logic [31:0] base, input logic [19:0] lim, input logic g,
                           input logic [31:0] new_eip, input logic [1:0] new_cpl);
        cs_desc            = '0;
        cs_desc.base_low   = base[23:0];
        cs_desc.base_high  = base[31:24];
        cs_desc.limit_low  = lim[15:0];
        cs_desc.limit_high = lim[19:16];
        cs_desc.access     = 8'h9A;       // present, readable code
        cs_desc.flags      = {g, 3'b100}; // 32-bit default size
        eip                = new_eip;
        cpl                = new_cpl;
        fetch_restart      = 1'b1;
        @(negedge clk);
        fetch_restart = 1'b0;
        req_addr_q.delete();  // older reads belong to the old window
        req_su_q.delete();
    endtask

    task automatic pop_entry(output fifo_entry_t e, output bit ok);
        int waited;
        waited = 0;
        while (!fifo_valid && waited < timeout) begin
            @(negedge clk);
            waited++;
        end
        ok = fifo_valid;
        e  = fifo_entry;
        if (!ok) begin
            failure_count++;
            $display("prefetch queue stayed empty for %0d cycles at %0t", timeout, $time);
        end else begin
            fifo_pop = 1'b1;  // head advances at the next rising edge
            @(negedge clk);
            fifo_pop = 1'b0;
        end
    endtask

    // mem_read_do at level for the given number of cycles in a row
    task automatic wait_read_level(input logic level, input int cycles);
        int run;
        int waited;
        run    = 0;
        waited = 0;
        while (run < cycles && waited < timeout) begin
            @(negedge clk);
            waited++;
            run = (mem_read_do === level) ? run + 1 : 0;
        end
        if (run < cycles) begin
            failure_count++;
            $display("memory read level never settled to %b at %0t", level, $time);
        end
    endtask

    // pops the stream of a window and checks each chunk and its read
    task automatic expect_stream(input logic [31:0] start, input logic [31:0] window,
                                 input logic su, input int max_chunks, output int chunks);
        fifo_entry_t exp_q[$];
        logic [31:0] addr_q[$];
        fifo_entry_t exp;
        fifo_entry_t got;
        logic [31:0] addr;
        logic [31:0] left;
        int          len;
        bit          ok;
        addr = start;
        left = window;
        while (left != 0 && exp_q.size() < max_chunks) begin
            len = `MEM_WORD_BYTES - int'(addr[1:0]);  // stop at the word end
            if (left < len) begin
                len = int'(left);  // window ends inside this word
            end
            exp = '0;
            for (int k = 0; k < len; k++) begin
                exp.data[8*k +: 8] = addr[7:0] + 8'(k);
            end
            exp.count = 3'(len);
            exp_q.push_back(exp);
            addr_q.push_back(addr);
            addr = addr + len;
            left = left - len;
        end
        chunks = exp_q.size();
        if (left == 0) begin
            exp             = '0;  // end of segment marker
            exp.limit_fault = 1'b1;
            exp_q.push_back(exp);
        end
        foreach (exp_q[i]) begin
            pop_entry(got, ok);
            if (!ok) begin
                return;
            end
            check_entry(got, exp_q[i]);
            if (i < chunks && req_addr_q.size() > i) begin
                check_request(req_addr_q[i], req_su_q[i], {addr_q[i][31:2], 2'b00}, su);
            end else if (i < chunks) begin
                failure_count++;
                $display("no memory read seen for chunk %0d at %0t", i, $time);
            end
        end
    endtask

    // after the marker nothing more is read or queued
    task automatic expect_idle(input int reads);
        repeat (10) @(negedge clk);
        compare_count(req_addr_q.size(), reads, "memory reads");
        compare_count(int'(fifo_valid), 0, "entries left in the queue");
        compare_count(int'(mem_read_do), 0, "read still active");
    endtask

    task automatic startup_stream();
        int n;
        expect_stream(`STARTUP_PREFETCH_LINEAR, `STARTUP_PREFETCH_LIMIT, 1'b0, 16, n);
        expect_idle(n);
    endtask

    task automatic unaligned_user();
        int n;
        restart(32'h0001_2340, 20'h00030, 1'b0, 32'h13, 2'd3);  // offset 3, user
        expect_stream(32'h0001_2353, 32'h30 - 32'h13 + 1, 1'b1, 16, n);
        expect_idle(n);
    endtask

    task automatic short_tail();
        int n;
        restart(32'h0000_1000, 20'h0002A, 1'b0, 32'h20, 2'd0);  // 11 bytes
        expect_stream(32'h0000_1020, 32'h2A - 32'h20 + 1, 1'b0, 16, n);
        expect_idle(n);
    endtask

    task automatic granular_limit();
        int n;
        restart(32'h0040_0000, 20'h00002, 1'b1, 32'h100, 2'd1);
        expect_stream(32'h0040_0100, 32'h2 * 4096 + 4095 - 32'h100 + 1, 1'b0, 16, n);
        restart(32'h0, 20'h00010, 1'b0, 32'h20, 2'd0);  // eip past the limit
        expect_stream(32'h20, 32'h0, 1'b0, 16, n);
        expect_idle(0);
    endtask

    task automatic backpressure();
        int n;
        restart(32'h0000_2000, 20'h0FFFF, 1'b0, 32'h0, 2'd0);
        wait_read_level(1'b0, 20);  // queue filled, reads stopped
        compare_count(req_addr_q.size(), `PREFETCH_FIFO_DEPTH - 1, "reads with a full queue");
        expect_stream(32'h0000_2000, 32'h10000, 1'b0, 12, n);
    endtask

    task automatic restart_in_flight();
        int n;
        restart(32'h0000_3000, 20'h0FFFF, 1'b0, 32'h0, 2'd0);
        mem_hold <= 1'b1;  // the next read stays outstanding
        wait_read_level(1'b1, 3);
        restart(32'h0000_5000, 20'h0FFFF, 1'b0, 32'h2, 2'd0);
        mem_hold <= 1'b0;  // stale data comes back now
        expect_stream(32'h0000_5002, 32'h10000 - 32'h2, 1'b0, 6, n);
    endtask

    initial begin
        pr_reset      = 1'b1;
        fetch_restart = 1'b0;
        cpl           = 2'd0;
        eip           = 32'h0;
        cs_desc       = '0;
        mem_done      = 1'b0;
        mem_data      = 32'h0;
        mem_hold      = 1'b0;
        fifo_pop      = 1'b0;
        repeat (3) @(negedge clk);
        pr_reset = 1'b0;
        startup_stream();
        unaligned_user();
        short_tail();
        granular_limit();
        backpressure();
        restart_in_flight();
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+common
common/prefetch_pkg.sv
prefetch/prefetch.sv
prefetch/fetch_engine.sv
prefetch/prefetch_fifo.sv
rtl/prefetch_top.sv
verif/tb_prefetch_top.sv

// ==== Bender.yml ====
package:
  name: prefetch

sources:
  - include_dirs:
      - common
    files:
      - common/prefetch_pkg.sv
      - prefetch/prefetch.sv
      - prefetch/fetch_engine.sv
      - prefetch/prefetch_fifo.sv
      - rtl/prefetch_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - verif/tb_prefetch_top.sv
